// File: Bender.yml
package:
  name: light_grid

sources:
  - design/light_grid_pkg.sv
  - design/bank_ram.sv
  - design/row_sweeper.sv
  - design/brightness_bank.sv
  - design/grid_sequencer.sv
  - design/light_grid_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/light_grid_tb.sv

// File: design/bank_ram.sv
module bank_ram
    import light_grid_pkg::*;
(
    input  logic                       clk,
    input  logic [ROW_ADDR_WIDTH-1:0]  rd_addr,
    output logic [BANK_DATA_WIDTH-1:0] rd_data,
    input  logic                       wr_en,
    input  logic [ROW_ADDR_WIDTH-1:0]  wr_addr,
    input  logic [BANK_DATA_WIDTH-1:0] wr_data
);

    logic [BANK_DATA_WIDTH-1:0] mem [GRID_ROWS];

    initial begin
        for (int i = 0; i < GRID_ROWS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

endmodule

// File: design/brightness_bank.sv
module brightness_bank
    import light_grid_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic [ROW_ADDR_WIDTH-1:0]   rd_row,
    input  logic [ROW_ADDR_WIDTH-1:0]   wr_row,
    input  logic                        wr_en,
    input  logic                        sum_en,
    input  logic                        clear_mode,
    input  light_op_e                   cmd_op,
    input  logic [POSITION_WIDTH-1:0]   cmd_start_col,
    input  logic [POSITION_WIDTH-1:0]   cmd_end_col,
    input  logic [POSITION_WIDTH-1:0]   pass_offset,
    input  logic [SUM_WIDTH-1:0]        acc_in,
    input  logic [BANK_INDEX_WIDTH-1:0] bank_index,
    output logic [SUM_WIDTH-1:0]        acc_out
);

    logic [BANK_DATA_WIDTH-1:0]                rd_data;
    logic [BANK_DATA_WIDTH-1:0]                wr_data;
    logic [BANK_DATA_WIDTH-1:0]                cells;
    logic [GRID_ROWS-1:0]                      row_live;
    logic                                      rd_live;
    logic [POSITION_WIDTH-1:0]                 bank_base;
    logic [COLS_PER_BANK-1:0][SUM_WIDTH-1:0]   col_sum;
    logic [SUM_WIDTH-1:0]                      bank_sum;

    bank_ram i_ram (
        .clk(clk),
        .rd_addr(rd_row),
        .rd_data(rd_data),
        .wr_en(wr_en),
        .wr_addr(wr_row),
        .wr_data(wr_data)
    );

    // Rows not written since reset read as zero
    always_ff @(posedge clk) begin
        if (reset) begin
            row_live <= '0;
        end else if (wr_en) begin
            row_live[wr_row] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        rd_live <= row_live[rd_row];
    end

    assign cells = rd_live ? rd_data : '0;
    assign bank_base = pass_offset + POSITION_WIDTH'(COLS_PER_BANK * bank_index);

    for (genvar j = 0; j < COLS_PER_BANK; j++) begin : g_col
        logic [CELL_WIDTH-1:0]     rd_cell;
        logic [CELL_WIDTH-1:0]     wr_cell;
        logic [POSITION_WIDTH-1:0] col_abs;
        logic                      selected;

        assign rd_cell = cells[j*CELL_WIDTH +: CELL_WIDTH];
        assign wr_data[j*CELL_WIDTH +: CELL_WIDTH] = wr_cell;
        assign col_abs = bank_base + POSITION_WIDTH'(j);
        assign selected = (cmd_start_col <= col_abs) && (col_abs <= cmd_end_col);

        always_ff @(posedge clk) begin
            if (clear_mode) begin
                wr_cell <= '0;
            end else if (selected) begin
                case (cmd_op)
                    TURN_OFF: wr_cell <= (rd_cell != '0) ? rd_cell - 1'b1 : rd_cell;
                    TOGGLE:   wr_cell <= rd_cell + CELL_WIDTH'(2);
                    RESERVED: wr_cell <= rd_cell;
                    TURN_ON:  wr_cell <= rd_cell + 1'b1;
                endcase
            end else begin
                wr_cell <= rd_cell;
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                col_sum[j] <= '0;
            end else if (sum_en) begin
                col_sum[j] <= col_sum[j] + SUM_WIDTH'(rd_cell);
            end
        end
    end

    always_comb begin
        bank_sum = '0;
        for (int k = 0; k < COLS_PER_BANK; k++) begin
            bank_sum = bank_sum + col_sum[k];
        end
    end

    // One stage of the chain across banks
    always_ff @(posedge clk) begin
        if (reset) begin
            acc_out <= '0;
        end else begin
            acc_out <= acc_in + bank_sum;
        end
    end

endmodule

// File: design/grid_sequencer.sv
module grid_sequencer
    import light_grid_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      instr_valid,
    input  logic                      instr_last,
    input  logic [COMMAND_WIDTH-1:0]  instr_data,
    input  logic                      update_done,
    input  logic                      sum_done,
    output logic                      instr_ready,
    output light_op_e                 cmd_op,
    output logic [POSITION_WIDTH-1:0] cmd_start_row,
    output logic [POSITION_WIDTH-1:0] cmd_end_row,
    output logic [POSITION_WIDTH-1:0] cmd_start_col,
    output logic [POSITION_WIDTH-1:0] cmd_end_col,
    output logic [POSITION_WIDTH-1:0] pass_offset,
    output logic                      start_update,
    output logic                      start_sum,
    output logic                      last_seen,
    output logic                      count_done
);

    seq_state_e                  state;
    seq_state_e                  next_state;
    logic [PASS_INDEX_WIDTH-1:0] pass_idx;
    logic                        transfer;
    logic                        final_pass;

    assign transfer = instr_valid && instr_ready;
    assign final_pass = (pass_idx == PASS_INDEX_WIDTH'(PASS_COUNT - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= WAIT_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            WAIT_RESET: next_state = ACCEPT;
            ACCEPT: begin
                if (transfer) begin
                    next_state = CAPTURE;
                end
            end
            CAPTURE: next_state = UPDATE;
            UPDATE: begin
                if (update_done) begin
                    next_state = last_seen ? START_SUM : ACCEPT;
                end
            end
            START_SUM: next_state = SUM;
            SUM: begin
                if (sum_done) begin
                    next_state = final_pass ? FINISHED : ACCEPT;
                end
            end
            FINISHED: next_state = FINISHED;
            default: next_state = WAIT_RESET;
        endcase
    end

    assign instr_ready = (state == ACCEPT);
    assign start_update = (state == CAPTURE);
    assign start_sum = (state == START_SUM);
    assign count_done = (state == FINISHED);

    // Fields from the top: op, start_row, start_col, end_row, end_col
    always_ff @(posedge clk) begin
        if (transfer) begin
            cmd_op <= light_op_e'(instr_data[4*POSITION_WIDTH +: OP_WIDTH]);
            cmd_start_row <= instr_data[3*POSITION_WIDTH +: POSITION_WIDTH];
            cmd_start_col <= instr_data[2*POSITION_WIDTH +: POSITION_WIDTH];
            cmd_end_row <= instr_data[POSITION_WIDTH +: POSITION_WIDTH];
            cmd_end_col <= instr_data[0 +: POSITION_WIDTH];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_seen <= 1'b0;
        end else if (transfer) begin
            last_seen <= instr_last;
        end
    end

    // Next pass starts once the clearing sum is through
    always_ff @(posedge clk) begin
        if (reset) begin
            pass_idx <= '0;
        end else if (state == SUM && sum_done && !final_pass) begin
            pass_idx <= pass_idx + 1'b1;
        end
    end

    assign pass_offset = POSITION_WIDTH'(pass_idx * COLS_PER_PASS);

endmodule

// File: design/light_grid_pkg.sv
package light_grid_pkg;

    // Grid geometry
    localparam int GRID_ROWS = 16;
    localparam int GRID_COLS = 24;
    localparam int COLS_PER_PASS = 12;
    localparam int PASS_COUNT = 2;
    localparam int PASS_INDEX_WIDTH = $clog2(PASS_COUNT);

    // Storage layout, six cells packed per RAM word
    localparam int COLS_PER_BANK = 6;
    localparam int BANK_COUNT = COLS_PER_PASS / COLS_PER_BANK;
    localparam int BANK_INDEX_WIDTH = $clog2(BANK_COUNT);
    localparam int CELL_WIDTH = 6;
    localparam int BANK_DATA_WIDTH = COLS_PER_BANK * CELL_WIDTH;

    localparam int POSITION_WIDTH = $clog2(GRID_COLS);
    localparam int ROW_ADDR_WIDTH = $clog2(GRID_ROWS);

    // Command word: op, start_row, start_col, end_row, end_col
    localparam int OP_WIDTH = 2;
    localparam int COMMAND_WIDTH = OP_WIDTH + 4 * POSITION_WIDTH;

    // Read address to write address distance in the row pipeline
    localparam int UPDATE_LATENCY = 3;

    // Enough for every cell at full brightness
    localparam int SUM_WIDTH =
        $clog2(GRID_ROWS * GRID_COLS * ((1 << CELL_WIDTH) - 1) + 1);

    typedef enum logic [OP_WIDTH-1:0] {
        TURN_OFF = 2'b00,
        TOGGLE   = 2'b01,
        RESERVED = 2'b10,
        TURN_ON  = 2'b11
    } light_op_e;

    typedef enum logic [2:0] {
        WAIT_RESET,
        ACCEPT,
        CAPTURE,
        UPDATE,
        START_SUM,
        SUM,
        FINISHED
    } seq_state_e;

endpackage

// File: design/light_grid_top.sv
module light_grid_top
    import light_grid_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     instr_valid,
    input  logic                     instr_last,
    input  logic [COMMAND_WIDTH-1:0] instr_data,
    output logic                     instr_ready,
    output logic                     count_done,
    output logic [SUM_WIDTH-1:0]     count_value
);

    light_op_e                 cmd_op;
    logic [POSITION_WIDTH-1:0] cmd_start_row;
    logic [POSITION_WIDTH-1:0] cmd_end_row;
    logic [POSITION_WIDTH-1:0] cmd_start_col;
    logic [POSITION_WIDTH-1:0] cmd_end_col;
    logic [POSITION_WIDTH-1:0] pass_offset;
    logic                      start_update;
    logic                      start_sum;
    logic                      update_done;
    logic                      sum_done;
    logic [ROW_ADDR_WIDTH-1:0] rd_row;
    logic [ROW_ADDR_WIDTH-1:0] wr_row;
    logic                      wr_en;
    logic                      sum_en;
    logic                      clear_mode;
    logic [SUM_WIDTH-1:0]      acc_chain [BANK_COUNT+1];

    grid_sequencer i_sequencer (
        .clk(clk),
        .reset(reset),
        .instr_valid(instr_valid),
        .instr_last(instr_last),
        .instr_data(instr_data),
        .update_done(update_done),
        .sum_done(sum_done),
        .instr_ready(instr_ready),
        .cmd_op(cmd_op),
        .cmd_start_row(cmd_start_row),
        .cmd_end_row(cmd_end_row),
        .cmd_start_col(cmd_start_col),
        .cmd_end_col(cmd_end_col),
        .pass_offset(pass_offset),
        .start_update(start_update),
        .start_sum(start_sum),
        .last_seen(),
        .count_done(count_done)
    );

    row_sweeper i_sweeper (
        .clk(clk),
        .reset(reset),
        .start_update(start_update),
        .start_sum(start_sum),
        .first_row(cmd_start_row),
        .last_row(cmd_end_row),
        .rd_row(rd_row),
        .wr_row(wr_row),
        .wr_en(wr_en),
        .sum_en(sum_en),
        .clear_mode(clear_mode),
        .update_done(update_done),
        .sum_done(sum_done)
    );

    assign acc_chain[0] = '0;

    for (genvar i = 0; i < BANK_COUNT; i++) begin : g_bank
        brightness_bank i_bank (
            .clk(clk),
            .reset(reset),
            .rd_row(rd_row),
            .wr_row(wr_row),
            .wr_en(wr_en),
            .sum_en(sum_en),
            .clear_mode(clear_mode),
            .cmd_op(cmd_op),
            .cmd_start_col(cmd_start_col),
            .cmd_end_col(cmd_end_col),
            .pass_offset(pass_offset),
            .acc_in(acc_chain[i]),
            .bank_index(BANK_INDEX_WIDTH'(i)),
            .acc_out(acc_chain[i+1])
        );
    end

    assign count_value = acc_chain[BANK_COUNT];

endmodule

// File: design/row_sweeper.sv
module row_sweeper
    import light_grid_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start_update,
    input  logic                      start_sum,
    input  logic [POSITION_WIDTH-1:0] first_row,
    input  logic [POSITION_WIDTH-1:0] last_row,
    output logic [ROW_ADDR_WIDTH-1:0] rd_row,
    output logic [ROW_ADDR_WIDTH-1:0] wr_row,
    output logic                      wr_en,
    output logic                      sum_en,
    output logic                      clear_mode,
    output logic                      update_done,
    output logic                      sum_done
);

    // Stage 0 issues the read, read data sits at stage 1, write at the last stage
    localparam int DATA_STAGE = 1;
    localparam int WR_STAGE = UPDATE_LATENCY - 1;

    logic [UPDATE_LATENCY-1:0][POSITION_WIDTH-1:0] row_pipe;
    logic [UPDATE_LATENCY-1:0]                     valid_pipe;
    logic [POSITION_WIDTH-1:0]                     stop_row;
    logic                                          last_write;

    assign rd_row = ROW_ADDR_WIDTH'(row_pipe[0]);
    assign wr_row = ROW_ADDR_WIDTH'(row_pipe[WR_STAGE]);
    assign wr_en = valid_pipe[WR_STAGE];
    assign sum_en = clear_mode && valid_pipe[DATA_STAGE];
    assign last_write = valid_pipe[WR_STAGE] && !valid_pipe[WR_STAGE-1];

    always_ff @(posedge clk) begin
        if (start_update) begin
            row_pipe[0] <= first_row;
            stop_row <= last_row;
        end else if (start_sum) begin
            row_pipe[0] <= '0;
            stop_row <= POSITION_WIDTH'(GRID_ROWS - 1);
        end else begin
            row_pipe[0] <= row_pipe[0] + 1'b1;
        end
        row_pipe[UPDATE_LATENCY-1:1] <= row_pipe[UPDATE_LATENCY-2:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
            clear_mode <= 1'b0;
            update_done <= 1'b0;
            sum_done <= 1'b0;
        end else begin
            valid_pipe <= {valid_pipe[UPDATE_LATENCY-2:0], 1'b0};
            update_done <= last_write && !clear_mode;
            sum_done <= last_write && clear_mode;
            if (start_update) begin
                valid_pipe[0] <= 1'b1;
                clear_mode <= 1'b0;
            end else if (start_sum) begin
                valid_pipe[0] <= 1'b1;
                clear_mode <= 1'b1;
            end else begin
                // Stop issuing once the final row has gone out
                valid_pipe[0] <= valid_pipe[0] && (row_pipe[0] != stop_row);
            end
        end
    end

endmodule

// File: dv/light_grid_tb.sv
module light_grid_tb
    import light_grid_pkg::*;
();

    localparam int TEST_COUNT = 6;
    localparam int WATCHDOG_TIME = TEST_COUNT * 40 * PASS_COUNT * (GRID_ROWS + 10) * 10;

    logic                     clk;
    logic                     power_on_reset;
    logic                     test_reset;
    logic                     reset;
    logic                     instr_valid;
    logic                     instr_last;
    logic [COMMAND_WIDTH-1:0] instr_data;
    logic                     instr_ready;
    logic                     count_done;
    logic [SUM_WIDTH-1:0]     count_value;

    logic [COMMAND_WIDTH-1:0] cmd_list [$];
    int expected_total = 0;
    int lists_sent = 0;
    int results_checked = 0;
    int error_count = 0;
    int test_count = 0;
    int failed_tests = 0;
    int test_errors_start = 0;

    assign reset = power_on_reset || test_reset;

    tb_clock_gen i_clock_gen (
        .clk(clk),
        .reset(power_on_reset)
    );

    light_grid_top i_dut (
        .clk(clk),
        .reset(reset),
        .instr_valid(instr_valid),
        .instr_last(instr_last),
        .instr_data(instr_data),
        .instr_ready(instr_ready),
        .count_done(count_done),
        .count_value(count_value)
    );

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("FAILED at time %0t: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            error_count++;
        end
    endtask

    function automatic logic [COMMAND_WIDTH-1:0] make_command(input light_op_e op,
            input int start_row, input int start_col, input int end_row, input int end_col);
        return {op, POSITION_WIDTH'(start_row), POSITION_WIDTH'(start_col),
                POSITION_WIDTH'(end_row), POSITION_WIDTH'(end_col)};
    endfunction

    function automatic logic [COMMAND_WIDTH-1:0] random_command();
        int r0;
        int r1;
        int c0;
        int c1;
        int swap;
        r0 = $urandom_range(GRID_ROWS - 1, 0);
        r1 = $urandom_range(GRID_ROWS - 1, 0);
        c0 = $urandom_range(GRID_COLS - 1, 0);
        c1 = $urandom_range(GRID_COLS - 1, 0);
        if (r0 > r1) begin
            swap = r0;
            r0 = r1;
            r1 = swap;
        end
        if (c0 > c1) begin
            swap = c0;
            c0 = c1;
            c1 = swap;
        end
        return make_command(light_op_e'($urandom_range(3, 0)), r0, c0, r1, c1);
    endfunction

    // Reference model over the whole grid, no pass split
    function automatic int grid_total();
        int grid [GRID_ROWS][GRID_COLS];
        int total;
        int op;
        int r0;
        int c0;
        int r1;
        int c1;
        logic [COMMAND_WIDTH-1:0] word;
        total = 0;
        for (int r = 0; r < GRID_ROWS; r++) begin
            for (int c = 0; c < GRID_COLS; c++) begin
                grid[r][c] = 0;
            end
        end
        for (int n = 0; n < cmd_list.size(); n++) begin
            word = cmd_list[n];
            op = word[COMMAND_WIDTH-1 -: OP_WIDTH];
            r0 = word[4*POSITION_WIDTH-1 -: POSITION_WIDTH];
            c0 = word[3*POSITION_WIDTH-1 -: POSITION_WIDTH];
            r1 = word[2*POSITION_WIDTH-1 -: POSITION_WIDTH];
            c1 = word[POSITION_WIDTH-1 -: POSITION_WIDTH];
            for (int r = r0; r <= r1; r++) begin
                for (int c = c0; c <= c1; c++) begin
                    if (op == TURN_ON) begin
                        grid[r][c] = grid[r][c] + 1;
                    end else if (op == TOGGLE) begin
                        grid[r][c] = grid[r][c] + 2;
                    end else if (op == TURN_OFF && grid[r][c] > 0) begin
                        grid[r][c] = grid[r][c] - 1;
                    end
                end
            end
        end
        for (int r = 0; r < GRID_ROWS; r++) begin
            for (int c = 0; c < GRID_COLS; c++) begin
                total = total + grid[r][c];
            end
        end
        return total;
    endfunction

    task automatic apply_reset();
        instr_valid = 1'b0;
        instr_last = 1'b0;
        test_reset = 1'b1;
        lists_sent = 0;
        repeat (16) begin
            @(posedge clk);
            #1;
        end
        check_value(int'(instr_ready), 0, "instr_ready low during reset");
        check_value(int'(count_done), 0, "count_done low during reset");
        test_reset = 1'b0;
    endtask

    // Ready sampled between edges matches what the next edge sees
    task automatic send_command(input logic [COMMAND_WIDTH-1:0] word, input logic last);
        logic ready_seen;
        instr_valid = 1'b1;
        instr_data = word;
        instr_last = last;
        ready_seen = 1'b0;
        while (!ready_seen) begin
            ready_seen = instr_ready;
            @(posedge clk);
            #1;
        end
        instr_valid = 1'b0;
        instr_last = 1'b0;
    endtask

    task automatic run_list(input int max_gap);
        int checks_before;
        int gap;
        logic [SUM_WIDTH-1:0] final_value;
        expected_total = grid_total();
        checks_before = results_checked;
        for (int p = 0; p < PASS_COUNT; p++) begin
            for (int i = 0; i < cmd_list.size(); i++) begin
                gap = $urandom_range(max_gap, 0);
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
                send_command(cmd_list[i], i == cmd_list.size() - 1);
            end
            lists_sent++;
        end
        while (results_checked == checks_before) begin
            @(posedge clk);
            #1;
        end
        final_value = count_value;
        repeat (5) begin
            @(posedge clk);
            #1;
        end
        check_value(int'(count_done), 1, "count_done held after finish");
        check_value(int'(count_value), int'(final_value), "count_value held after finish");
    endtask

    task automatic begin_test();
        test_count++;
        test_errors_start = error_count;
        cmd_list.delete();
        apply_reset();
    endtask

    task automatic end_test(input string name);
        if (error_count == test_errors_start) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", test_count, name,
                     error_count - test_errors_start);
            failed_tests++;
        end
    endtask

    // Compare the total once count_done rises
    initial begin
        forever begin
            @(posedge count_done);
            @(negedge clk);
            check_value(lists_sent, PASS_COUNT, "count_done before second list finished");
            check_value(int'(count_value), expected_total, "count_value against model total");
            results_checked++;
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired after %0d time units, the DUT stopped responding",
                 WATCHDOG_TIME);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        instr_valid = 1'b0;
        instr_last = 1'b0;
        instr_data = '0;
        test_reset = 1'b0;
        void'($urandom(82));
        @(negedge power_on_reset);

        begin_test();
        cmd_list.push_back(make_command(TURN_ON, 2, 1, 5, 4));
        run_list(0);
        end_test("single turn-on");

        begin_test();
        cmd_list.push_back(make_command(TURN_ON, 3, 2, 6, 9));
        cmd_list.push_back(make_command(TURN_OFF, 0, 0, 10, 15));
        cmd_list.push_back(make_command(TURN_OFF, 2, 1, 7, 10));
        cmd_list.push_back(make_command(TURN_OFF, 3, 2, 6, 9));
        cmd_list.push_back(make_command(TURN_ON, 5, 5, 5, 5));
        run_list(0);
        end_test("turn-off stops at zero");

        begin_test();
        cmd_list.push_back(make_command(TOGGLE, 0, 3, 15, 9));
        cmd_list.push_back(make_command(RESERVED, 0, 0, 15, 23));
        cmd_list.push_back(make_command(TOGGLE, 4, 5, 7, 6));
        cmd_list.push_back(make_command(TURN_OFF, 1, 0, 2, 11));
        run_list(0);
        end_test("toggle and reserved");

        begin_test();
        cmd_list.push_back(make_command(TURN_ON, 0, 10, 15, 13));
        cmd_list.push_back(make_command(TOGGLE, 3, 8, 8, 20));
        cmd_list.push_back(make_command(TURN_OFF, 5, 11, 5, 12));
        cmd_list.push_back(make_command(TURN_ON, 0, 0, 15, 23));
        run_list(0);
        end_test("pass border");

        begin_test();
        for (int i = 0; i < 30; i++) begin
            cmd_list.push_back(random_command());
        end
        run_list(3);
        end_test("random list with gaps");

        // Partial list lights the whole grid, then reset and a fresh list
        begin_test();
        for (int i = 0; i < 4; i++) begin
            send_command(make_command(TURN_ON, 0, 0, GRID_ROWS - 1, GRID_COLS - 1), 1'b0);
        end
        apply_reset();
        for (int i = 0; i < 3; i++) begin
            cmd_list.push_back(random_command());
        end
        run_list(1);
        end_test("reset mid-list");

        $display("tests run: %0d, tests failed: %0d, failed checks: %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: dv/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Power-on reset, released just after an edge
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// File: filelist.f
design/light_grid_pkg.sv
design/bank_ram.sv
design/row_sweeper.sv
design/brightness_bank.sv
design/grid_sequencer.sv
design/light_grid_top.sv
dv/tb_clock_gen.sv
dv/light_grid_tb.sv
